/* rtl/core_pkg.sv */
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_lui,
        op_load,
        op_store,
        op_none
    } alu_op_t;

    localparam word_t reset_pc = 32'h1c00_0000;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcode fields, compared against the top bits of the instruction word
    localparam logic [16:0] opc_add_w   = 17'h00020;  // inst[31:15]
    localparam logic [16:0] opc_sub_w   = 17'h00022;
    localparam logic [16:0] opc_slt     = 17'h00024;
    localparam logic [16:0] opc_and     = 17'h00029;
    localparam logic [16:0] opc_or      = 17'h0002a;
    localparam logic [16:0] opc_xor     = 17'h0002b;
    localparam logic [9:0]  opc_addi_w  = 10'h00a;    // inst[31:22]
    localparam logic [9:0]  opc_ld_w    = 10'h0a2;
    localparam logic [9:0]  opc_st_w    = 10'h0a6;
    localparam logic [6:0]  opc_lu12i_w = 7'h0a;      // inst[31:25]
    localparam logic [5:0]  opc_beq     = 6'h16;      // inst[31:26]
    localparam logic [5:0]  opc_bne     = 6'h17;
    localparam logic [5:0]  opc_b       = 6'h14;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic reg_idx_t inst_rd(word_t inst);
        return inst[4:0];
    endfunction

    function automatic reg_idx_t inst_rj(word_t inst);
        return inst[9:5];
    endfunction

    function automatic reg_idx_t inst_rk(word_t inst);
        return inst[14:10];
    endfunction

    function automatic word_t sext_si12(word_t inst);
        return {{20{inst[21]}}, inst[21:10]};
    endfunction

    // Branch offsets come back as byte offsets, already shifted by two
    function automatic word_t br_offs16(word_t inst);
        return {{14{inst[25]}}, inst[25:10], 2'b00};
    endfunction

    function automatic word_t br_offs26(word_t inst);
        return {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
    endfunction

endpackage

/* rtl/stage_ifs.sv */
// Decode to execute
interface issue_if;
    import core_pkg::*;

    logic     valid;
    logic     ready;
    word_t    pc;
    alu_op_t  op;
    reg_idx_t dest;        // Zero when nothing is written
    word_t    src1;
    word_t    src2;
    word_t    store_data;

    modport producer (
        output valid, pc, op, dest, src1, src2, store_data,
        input  ready
    );

    modport consumer (
        input  valid, pc, op, dest, src1, src2, store_data,
        output ready
    );
endinterface

// Execute to writeback
interface retire_if;
    import core_pkg::*;

    logic     valid;
    logic     ready;
    word_t    pc;
    reg_idx_t dest;
    logic     is_load;
    word_t    result;      // Holds the address for a load

    modport producer (
        output valid, pc, dest, is_load, result,
        input  ready
    );

    modport consumer (
        input  valid, pc, dest, is_load, result,
        output ready
    );
endinterface

/* rtl/fetch_stage.sv */
module fetch_stage (
    input  logic            clk,
    input  logic            reset,
    input  logic            decode_ready,
    input  logic            redirect,
    input  core_pkg::word_t redirect_pc,
    output logic            fetch_valid,
    output core_pkg::word_t fetch_pc,
    output logic            inst_sram_en,
    output logic [3:0]      inst_sram_we,
    output core_pkg::word_t inst_sram_addr,
    output core_pkg::word_t inst_sram_wdata
);
    import core_pkg::*;

    logic  started;
    logic  jump_q;      // Next request goes to jump_pc_q
    word_t jump_pc_q;

    // fetch_pc is the address of the word that decode sees this cycle
    always_comb begin
        if (jump_q)
            inst_sram_addr = jump_pc_q;
        else if (fetch_valid && !decode_ready)
            inst_sram_addr = fetch_pc;  // Re-read the word decode is holding
        else
            inst_sram_addr = fetch_pc + 32'd4;
    end

    assign inst_sram_en    = started;
    assign inst_sram_we    = 4'b0000;
    assign inst_sram_wdata = '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            started     <= 1'b0;
            fetch_valid <= 1'b0;
            jump_q      <= 1'b1;
            jump_pc_q   <= reset_pc;
        end else begin
            started <= 1'b1;
            if (started) begin
                fetch_valid <= !redirect;  // The word in flight is squashed
                jump_q      <= redirect;
                if (redirect)
                    jump_pc_q <= redirect_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (started)
            fetch_pc <= inst_sram_addr;
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        fetch_valid |-> fetch_pc[1:0] == 2'b00);

endmodule

/* rtl/regfile.sv */
module regfile (
    input  logic               clk,
    input  core_pkg::reg_idx_t raddr1,
    input  core_pkg::reg_idx_t raddr2,
    input  core_pkg::reg_idx_t waddr,
    input  logic               we,
    input  core_pkg::word_t    wdata,
    output core_pkg::word_t    rdata1,
    output core_pkg::word_t    rdata2
);
    import core_pkg::*;

    word_t regs [32];

    // A write in the same cycle is passed straight through
    function automatic word_t read_port(reg_idx_t raddr);
        if (raddr == '0)
            return '0;
        if (we && waddr == raddr)
            return wdata;
        return regs[raddr];
    endfunction

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

    always_ff @(posedge clk) begin
        if (we && waddr != '0)
            regs[waddr] <= wdata;
    end

endmodule

/* rtl/decode_stage.sv */
module decode_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               fetch_valid,
    input  core_pkg::word_t    fetch_pc,
    input  core_pkg::word_t    inst,
    input  core_pkg::word_t    rdata1,
    input  core_pkg::word_t    rdata2,
    input  core_pkg::reg_idx_t ex_dest,
    input  logic               ex_busy,
    output logic               decode_ready,
    output logic               redirect,
    output core_pkg::word_t    redirect_pc,
    output core_pkg::reg_idx_t raddr1,
    output core_pkg::reg_idx_t raddr2,
    issue_if.producer          issue
);
    import core_pkg::*;

    logic     is_add, is_sub, is_slt, is_and, is_or, is_xor, is_rr;
    logic     is_addi, is_lu12i, is_ld, is_st;
    logic     is_beq, is_bne, is_b;
    logic     uses_rj, uses_r2;
    logic     hazard;
    logic     taken;
    reg_idx_t rd;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction match
    assign is_add   = inst[31:15] == opc_add_w;
    assign is_sub   = inst[31:15] == opc_sub_w;
    assign is_slt   = inst[31:15] == opc_slt;
    assign is_and   = inst[31:15] == opc_and;
    assign is_or    = inst[31:15] == opc_or;
    assign is_xor   = inst[31:15] == opc_xor;
    assign is_addi  = inst[31:22] == opc_addi_w;
    assign is_ld    = inst[31:22] == opc_ld_w;
    assign is_st    = inst[31:22] == opc_st_w;
    assign is_lu12i = inst[31:25] == opc_lu12i_w;
    assign is_beq   = inst[31:26] == opc_beq;
    assign is_bne   = inst[31:26] == opc_bne;
    assign is_b     = inst[31:26] == opc_b;

    assign is_rr = is_add || is_sub || is_slt || is_and || is_or || is_xor;

    // Stores and compare branches read rd on the second port
    assign rd     = inst_rd(inst);
    assign raddr1 = inst_rj(inst);
    assign raddr2 = (is_st || is_beq || is_bne) ? rd : inst_rk(inst);

    assign uses_rj = is_rr || is_addi || is_ld || is_st || is_beq || is_bne;
    assign uses_r2 = is_rr || is_st || is_beq || is_bne;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Interlock
    // Results in writeback reach us through the register file bypass
    assign hazard = ex_busy && ex_dest != '0 &&
                    ((uses_rj && ex_dest == raddr1) || (uses_r2 && ex_dest == raddr2));

    assign issue.valid  = fetch_valid && !hazard;
    assign decode_ready = issue.ready && !(fetch_valid && hazard);

    assign issue.pc         = fetch_pc;
    assign issue.src1       = rdata1;
    assign issue.store_data = rdata2;

    always_comb begin
        issue.op   = op_none;   // Branches and unknown encodings
        issue.dest = '0;
        issue.src2 = rdata2;
        if (is_rr || is_addi || is_lu12i || is_ld)
            issue.dest = rd;
        if (is_addi || is_ld || is_st)
            issue.src2 = sext_si12(inst);
        else if (is_lu12i)
            issue.src2 = {inst[24:5], 12'b0};
        if (is_add || is_addi)
            issue.op = op_add;
        else if (is_sub)
            issue.op = op_sub;
        else if (is_slt)
            issue.op = op_slt;
        else if (is_and)
            issue.op = op_and;
        else if (is_or)
            issue.op = op_or;
        else if (is_xor)
            issue.op = op_xor;
        else if (is_lu12i)
            issue.op = op_lui;
        else if (is_ld)
            issue.op = op_load;
        else if (is_st)
            issue.op = op_store;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Branch resolution
    assign taken = is_b || (is_beq && rdata1 == rdata2) || (is_bne && rdata1 != rdata2);

    assign redirect    = issue.valid && issue.ready && taken;  // Only once the branch leaves
    assign redirect_pc = fetch_pc + (is_b ? br_offs26(inst) : br_offs16(inst));

    // A stalled instruction is presented again in the next cycle
    a_stall_holds: assert property (@(posedge clk) disable iff (reset)
        fetch_valid && !decode_ready |=>
            fetch_valid && $stable({issue.pc, issue.op, issue.dest}));

endmodule

/* rtl/execute_stage.sv */
module execute_stage (
    input  logic               clk,
    input  logic               reset,
    issue_if.consumer          issue,
    retire_if.producer         retire,
    output core_pkg::reg_idx_t ex_dest,
    output logic               ex_busy,
    output logic               data_sram_en,
    output logic [3:0]         data_sram_we,
    output core_pkg::word_t    data_sram_addr,
    output core_pkg::word_t    data_sram_wdata
);
    import core_pkg::*;

    logic     valid_q;
    word_t    pc_q;
    alu_op_t  op_q;
    reg_idx_t dest_q;
    word_t    src1_q;
    word_t    src2_q;
    word_t    store_q;
    word_t    result;
    logic     handoff;

    assign issue.ready = !valid_q || retire.ready;

    always_ff @(posedge clk) begin
        if (reset)
            valid_q <= 1'b0;
        else if (issue.ready)
            valid_q <= issue.valid;
    end

    always_ff @(posedge clk) begin
        if (issue.valid && issue.ready) begin
            pc_q    <= issue.pc;
            op_q    <= issue.op;
            dest_q  <= issue.dest;
            src1_q  <= issue.src1;
            src2_q  <= issue.src2;
            store_q <= issue.store_data;
        end
    end

    // Loads and stores use the adder for the address
    always_comb begin
        case (op_q)
            op_add, op_load, op_store: result = src1_q + src2_q;
            op_sub:  result = src1_q - src2_q;
            op_and:  result = src1_q & src2_q;
            op_or:   result = src1_q | src2_q;
            op_xor:  result = src1_q ^ src2_q;
            op_slt:  result = {31'b0, $signed(src1_q) < $signed(src2_q)};
            op_lui:  result = src2_q;
            default: result = '0;
        endcase
    end

    assign retire.valid   = valid_q;
    assign retire.pc      = pc_q;
    assign retire.dest    = dest_q;
    assign retire.is_load = op_q == op_load;
    assign retire.result  = result;

    assign ex_dest = dest_q;
    assign ex_busy = valid_q;

    // The data SRAM sees the access as the instruction moves on
    assign handoff         = valid_q && retire.ready;
    assign data_sram_en    = handoff && (op_q == op_load || op_q == op_store);
    assign data_sram_we    = (handoff && op_q == op_store) ? 4'b1111 : 4'b0000;
    assign data_sram_addr  = result;
    assign data_sram_wdata = store_q;

endmodule

/* rtl/writeback_stage.sv */
module writeback_stage (
    input  logic               clk,
    input  logic               reset,
    input  core_pkg::word_t    data_sram_rdata,
    retire_if.consumer         retire,
    output logic               rf_we,
    output core_pkg::reg_idx_t rf_waddr,
    output core_pkg::word_t    rf_wdata,
    output core_pkg::word_t    debug_wb_pc,
    output logic [3:0]         debug_wb_rf_we,
    output core_pkg::reg_idx_t debug_wb_rf_wnum,
    output core_pkg::word_t    debug_wb_rf_wdata
);
    import core_pkg::*;

    logic     valid_q;
    word_t    pc_q;
    reg_idx_t dest_q;
    logic     is_load_q;
    word_t    result_q;

    assign retire.ready = 1'b1;  // Takes one cycle and never stalls

    always_ff @(posedge clk) begin
        if (reset)
            valid_q <= 1'b0;
        else
            valid_q <= retire.valid;
    end

    always_ff @(posedge clk) begin
        if (retire.valid) begin
            pc_q      <= retire.pc;
            dest_q    <= retire.dest;
            is_load_q <= retire.is_load;
            result_q  <= retire.result;
        end
    end

    // Load data arrives from the SRAM in this cycle
    assign rf_wdata = is_load_q ? data_sram_rdata : result_q;
    assign rf_waddr = dest_q;
    assign rf_we    = valid_q && dest_q != '0;

    assign debug_wb_pc       = pc_q;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dest_q;
    assign debug_wb_rf_wdata = rf_wdata;

    a_load_data_known: assert property (@(posedge clk) disable iff (reset)
        rf_we && is_load_q |-> !$isunknown(data_sram_rdata));

endmodule

/* rtl/core_top.sv */
module core_top (
    input  logic               clk,
    input  logic               reset,
    // Instruction SRAM
    output logic               inst_sram_en,
    output logic [3:0]         inst_sram_we,
    output core_pkg::word_t    inst_sram_addr,
    output core_pkg::word_t    inst_sram_wdata,
    input  core_pkg::word_t    inst_sram_rdata,
    // Data SRAM
    output logic               data_sram_en,
    output logic [3:0]         data_sram_we,
    output core_pkg::word_t    data_sram_addr,
    output core_pkg::word_t    data_sram_wdata,
    input  core_pkg::word_t    data_sram_rdata,
    // Writeback trace
    output core_pkg::word_t    debug_wb_pc,
    output logic [3:0]         debug_wb_rf_we,
    output core_pkg::reg_idx_t debug_wb_rf_wnum,
    output core_pkg::word_t    debug_wb_rf_wdata
);
    import core_pkg::*;

    logic     fetch_valid;
    word_t    fetch_pc;
    logic     decode_ready;
    logic     redirect;
    word_t    redirect_pc;
    reg_idx_t rf_raddr1, rf_raddr2;
    word_t    rf_rdata1, rf_rdata2;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;
    reg_idx_t ex_dest;
    logic     ex_busy;

    issue_if  issue ();
    retire_if retire ();

    fetch_stage u_fetch (
        .clk, .reset, .decode_ready, .redirect, .redirect_pc, .fetch_valid, .fetch_pc,
        .inst_sram_en, .inst_sram_we, .inst_sram_addr, .inst_sram_wdata
    );

    decode_stage u_decode (
        .clk, .reset, .fetch_valid, .fetch_pc,
        .inst   (inst_sram_rdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .ex_dest, .ex_busy, .decode_ready, .redirect, .redirect_pc,
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .issue  (issue)
    );

    regfile u_regfile (
        .clk,
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .waddr  (rf_waddr),
        .we     (rf_we),
        .wdata  (rf_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    execute_stage u_execute (
        .clk, .reset, .issue (issue), .retire (retire), .ex_dest, .ex_busy,
        .data_sram_en, .data_sram_we, .data_sram_addr, .data_sram_wdata
    );

    writeback_stage u_writeback (
        .clk, .reset, .data_sram_rdata, .retire (retire), .rf_we, .rf_waddr, .rf_wdata,
        .debug_wb_pc, .debug_wb_rf_we, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

endmodule

/* bench/isa_model.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

typedef struct packed {
    word_t    pc;
    logic     we;
    reg_idx_t num;
    word_t    data;
} trace_t;

localparam logic [16:0] enc_add = 17'h00020;
localparam logic [16:0] enc_sub = 17'h00022;
localparam logic [16:0] enc_slt = 17'h00024;
localparam logic [16:0] enc_and = 17'h00029;
localparam logic [16:0] enc_or  = 17'h0002a;
localparam logic [16:0] enc_xor = 17'h0002b;
localparam logic [5:0]  enc_beq = 6'h16;
localparam logic [5:0]  enc_bne = 6'h17;
localparam word_t       b_self  = 32'h5000_0000;  // b 0, the end of every program
localparam logic [16:0] rr_ops [6] = '{enc_add, enc_sub, enc_slt, enc_and, enc_or, enc_xor};

word_t m_regs [32] = '{default: 32'h0};
word_t m_pc;
word_t m_dmem [word_t];

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Architectural step, one instruction at m_pc
function automatic trace_t step(word_t inst);
    trace_t   t;
    reg_idx_t rd;
    word_t    vj, vk, vd, si, val;
    logic     wr;
    rd   = inst[4:0];
    vj   = m_regs[inst[9:5]];
    vk   = m_regs[inst[14:10]];
    vd   = m_regs[rd];              // Stores and compare branches read rd
    si   = {{20{inst[21]}}, inst[21:10]};
    wr   = 1'b1;
    val  = '0;
    t.pc = m_pc;
    m_pc = m_pc + 32'd4;
    if (inst[31:15] == enc_add || inst[31:22] == 10'h00a)
        val = vj + ((inst[31:22] == 10'h00a) ? si : vk);
    else if (inst[31:15] == enc_sub)
        val = vj - vk;
    else if (inst[31:15] == enc_slt)
        val = ($signed(vj) < $signed(vk)) ? 32'd1 : 32'd0;
    else if (inst[31:15] == enc_and)
        val = vj & vk;
    else if (inst[31:15] == enc_or)
        val = vj | vk;
    else if (inst[31:15] == enc_xor)
        val = vj ^ vk;
    else if (inst[31:25] == 7'h0a)
        val = {inst[24:5], 12'h000};
    else if (inst[31:22] == 10'h0a2)
        val = m_dmem.exists(vj + si) ? m_dmem[vj + si] : fill_data(vj + si);
    else begin
        wr = 1'b0;
        if (inst[31:22] == 10'h0a6)
            m_dmem[vj + si] = vd;
        else if ((inst[31:26] == enc_beq && vj == vd) || (inst[31:26] == enc_bne && vj != vd))
            m_pc = t.pc + {{14{inst[25]}}, inst[25:10], 2'b00};
        else if (inst[31:26] == 6'h14)
            m_pc = t.pc + {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
    end
    t.we   = wr && rd != 5'd0;    // r0 writes leave no trace
    t.num  = rd;
    t.data = val;
    if (t.we)
        m_regs[rd] = val;
    return t;
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Program builders
task automatic start_program();
    for (int i = 0; i < 256; i++)
        imem[i] = ~(reset_pc + word_t'(i << 2));
    prog_len = 0;
endtask

task automatic emit(word_t inst);
    imem[prog_len] = inst;
    prog_len++;
endtask

task automatic rr(logic [16:0] opc, int rd, int rj, int rk);
    emit({opc, rk[4:0], rj[4:0], rd[4:0]});
endtask

task automatic addi(int rd, int rj, int si);
    emit({10'h00a, si[11:0], rj[4:0], rd[4:0]});
endtask

task automatic lu12i(int rd, int si);
    emit({7'h0a, si[19:0], rd[4:0]});
endtask

task automatic ldw(int rd, int rj, int si);
    emit({10'h0a2, si[11:0], rj[4:0], rd[4:0]});
endtask

task automatic stw(int rd, int rj, int si);
    emit({10'h0a6, si[11:0], rj[4:0], rd[4:0]});
endtask

task automatic br(logic [5:0] opc, int rj, int rd, int offs);
    emit({opc, offs[15:0], rj[4:0], rd[4:0]});
endtask

task automatic jump(int offs);
    emit({6'h14, offs[15:0], offs[25:16]});
endtask

`endif

/* bench/tb_core.sv */
module tb_core;
    timeunit 1ns;
    timeprecision 1ps;
    import core_pkg::*;

    logic     clk = 1'b0;
    logic     reset;
    word_t    inst_sram_rdata, data_sram_rdata;
    logic     inst_sram_en, data_sram_en;
    logic [3:0] inst_sram_we, data_sram_we, debug_wb_rf_we;
    word_t    inst_sram_addr, inst_sram_wdata, data_sram_addr, data_sram_wdata;
    word_t    debug_wb_pc, debug_wb_rf_wdata;
    reg_idx_t debug_wb_rf_wnum;

    word_t imem [256];
    int    prog_len;
    word_t dmem [word_t];
    logic  ien_q, den_q;
    logic [3:0] dwe_q;
    word_t ia_q, da_q, dwd_q;

    int     seed = 30;
    int     errors, tests_run, tests_failed, idle;
    logic   running = 1'b0;
    logic   fetch_pending = 1'b0;

    function automatic word_t fill_data(word_t addr);
        return addr ^ 32'h5a5a_a5a5;
    endfunction

    function automatic word_t imem_read(word_t addr);
        word_t off;
        off = addr - reset_pc;
        if (off < 32'd1024)
            return imem[off[9:2]];
        return ~addr;
    endfunction

    `include "isa_model.svh"

    trace_t exp_q [$];

    core_top dut (.*);

    always #4 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // The SRAM models take the address on the rising edge and drive data at the fall
    always @(posedge clk) begin
        ien_q <= inst_sram_en;
        ia_q  <= inst_sram_addr;
        den_q <= data_sram_en;
        dwe_q <= data_sram_we;
        da_q  <= data_sram_addr;
        dwd_q <= data_sram_wdata;
    end

    always @(negedge clk) begin
        if (ien_q === 1'b1)
            inst_sram_rdata <= imem_read(ia_q);
        if (den_q === 1'b1) begin
            if (dwe_q != 4'h0)
                dmem[da_q] = dwd_q;
            data_sram_rdata <= dmem.exists(da_q) ? dmem[da_q] : fill_data(da_q);
        end
    end

    task automatic check(string name, word_t got, word_t want);
        if (got !== want) begin
            $display("FAILED %s: got %h, expected %h", name, got, want);
            errors++;
        end
    endtask

    // The trace checker compares each register write with the next expected one
    always @(posedge clk) begin
        if (!reset && running) begin
            if (fetch_pending && inst_sram_en) begin
                check("inst_sram_addr", inst_sram_addr, reset_pc);
                fetch_pending = 1'b0;
            end
            check("inst_sram_we", {28'b0, inst_sram_we}, 32'h0);
            check("inst_sram_wdata", inst_sram_wdata, 32'h0);
            if (debug_wb_rf_we != 4'h0) begin
                idle = 0;
                if (exp_q.size() == 0) begin
                    $display("Unexpected write of r%0d at pc %h", debug_wb_rf_wnum, debug_wb_pc);
                    errors++;
                end else begin
                    check("debug_wb_pc", debug_wb_pc, exp_q[0].pc);
                    check("debug_wb_rf_we", {28'b0, debug_wb_rf_we}, 32'hf);
                    check("debug_wb_rf_wnum", {27'b0, debug_wb_rf_wnum}, {27'b0, exp_q[0].num});
                    check("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_q[0].data);
                    void'(exp_q.pop_front());
                end
            end else
                idle++;
        end
    end

    // Entered on a falling edge
    task automatic apply_reset();
        reset = 1'b1;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            @(negedge clk);
            check("debug_wb_rf_we", {28'b0, debug_wb_rf_we}, 32'h0);
            check("data_sram_we", {28'b0, data_sram_we}, 32'h0);
        end
        reset = 1'b0;
        fetch_pending = 1'b1;
    endtask

    task automatic run_test(string name, bit mem_check, bit interrupt);
        int     start_errors;
        int     steps;
        int     cycles;
        word_t  inst;
        trace_t t;
        start_errors = errors;
        exp_q.delete();
        m_pc = reset_pc;
        steps = 0;
        inst = imem_read(m_pc);
        while (inst != b_self && steps < 2000) begin
            t = step(inst);
            if (t.we)
                exp_q.push_back(t);
            inst = imem_read(m_pc);
            steps++;
        end
        if (inst != b_self) begin
            $display("Model of %s never reached its final branch", name);
            errors++;
        end
        if (interrupt) begin
            apply_reset();
            repeat (6) @(negedge clk);  // Reset again with the pipeline full
        end
        apply_reset();
        idle = 0;
        running = 1'b1;
        cycles = 0;
        while (!(exp_q.size() == 0 && idle >= 20) && cycles < 5000) begin
            @(negedge clk);
            cycles++;
        end
        running = 1'b0;
        if (cycles >= 5000) begin
            $display("Timeout in %s with %0d writes never seen", name, exp_q.size());
            errors++;
        end
        if (mem_check) begin
            foreach (m_dmem[a])
                check($sformatf("dmem[%h]", a), dmem.exists(a) ? dmem[a] : fill_data(a), m_dmem[a]);
            foreach (dmem[a]) begin
                if (!m_dmem.exists(a)) begin
                    $display("Data memory written at %h where the model wrote nothing", a);
                    errors++;
                end
            end
        end
        tests_run++;
        if (errors != start_errors)
            tests_failed++;
        $display("Test %s: %s", name, (errors == start_errors) ? "ok" : "errors");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic build_alu();
        int rd;
        for (int r = 1; r <= 8; r++) begin
            lu12i(r, $random(seed));
            addi(r, r, $random(seed));
        end
        for (int i = 0; i < 40; i++) begin
            rd = (i % 8 == 3) ? 0 : {$random(seed)} % 9;  // Some writes go to r0
            rr(rr_ops[{$random(seed)} % 6], rd, {$random(seed)} % 9, {$random(seed)} % 9);
        end
        jump(0);
    endtask

    task automatic build_imm();
        addi(1, 0, -1);
        addi(2, 0, -2048);
        addi(3, 0, 2047);
        lu12i(4, 'h80000);
        lu12i(5, 'hfffff);
        addi(5, 5, -1);
        lu12i(6, 'habcde);
        addi(7, 6, -2048);
        jump(0);
    endtask

    task automatic build_chain();
        addi(1, 0, 5);
        addi(2, 1, 3);
        rr(enc_add, 3, 2, 1);
        rr(enc_sub, 4, 3, 2);
        rr(enc_xor, 1, 4, 3);
        rr(enc_and, 2, 1, 3);
        rr(enc_or, 3, 2, 4);
        rr(enc_slt, 4, 1, 3);
        lu12i(10, 'h12345);
        addi(10, 10, 'h678);
        rr(enc_add, 11, 10, 10);
        rr(enc_sub, 11, 11, 10);
        jump(0);
    endtask

    task automatic build_mem();
        lu12i(20, 1);               // Base address 0x1000
        addi(21, 0, 'h123);
        stw(21, 20, 0);
        ldw(22, 20, 0);             // Load right behind the store
        addi(23, 0, -5);
        stw(23, 20, 4);
        stw(21, 20, 8);
        ldw(24, 20, 4);
        rr(enc_add, 25, 24, 22);
        ldw(26, 20, 12);            // Never written
        stw(26, 20, -4);
        ldw(27, 20, -4);
        rr(enc_xor, 28, 27, 26);
        jump(0);
    endtask

    task automatic build_branch();
        addi(5, 0, 3);
        addi(6, 0, 0);
        br(enc_beq, 5, 0, 4);       // Loop exit
        addi(6, 6, 7);
        addi(5, 5, -1);
        jump(-3);
        jump(2);
        addi(7, 0, 'h55);
        br(enc_bne, 6, 0, 2);
        addi(7, 0, 'h66);
        br(enc_beq, 6, 0, 2);       // Not taken
        addi(8, 0, 1);
        br(enc_bne, 0, 0, 2);
        addi(9, 8, 2);
        jump(0);
    endtask

    initial begin
        reset = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        @(negedge clk);
        start_program();
        build_alu();
        run_test("alu_random", 1'b0, 1'b0);
        start_program();
        build_imm();
        run_test("immediates", 1'b0, 1'b0);
        start_program();
        build_chain();
        run_test("dependencies", 1'b0, 1'b0);
        start_program();
        build_mem();
        run_test("load_store", 1'b1, 1'b0);
        start_program();
        build_branch();
        run_test("branches", 1'b0, 1'b0);
        start_program();
        build_mem();
        run_test("reset", 1'b1, 1'b1);
        $display("Tests run %0d, with errors %0d, error count %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+bench
rtl/core_pkg.sv
rtl/stage_ifs.sv
rtl/fetch_stage.sv
rtl/regfile.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/core_top.sv
bench/tb_core.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_core -f vlog.f -o tb_core_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_core_sim > sim.log 2>&1
cat sim.log
grep -q "All tests passed" sim.log && exit 0 || exit 1
